/* project.f */
+incdir+rtl
rtl/neoled_pkg.sv
rtl/neoled_regs.sv
rtl/neoled_fifo.sv
rtl/neoled_tick_gen.sv
rtl/neoled_serializer.sv
rtl/neoled_top.sv
testbench/neoled_tb.sv

/* Bender.yml */
package:
  name: neoled

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/neoled_pkg.sv
      - rtl/neoled_regs.sv
      - rtl/neoled_fifo.sv
      - rtl/neoled_tick_gen.sv
      - rtl/neoled_serializer.sv
      - rtl/neoled_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/neoled_tb.sv

/* testbench/neoled_tb.sv */
// smart-LED transmitter testbench
// directed tests over the register bus: read-back, RGB and RGBW
// transmission, FIFO flags with interrupt, strobe command and disable
`timescale 1ns/1ps
`include "neoled_defs.svh"

module neoled_tb import neoled_pkg::*; ();

    localparam int BUS_TIMEOUT = 20;    // cycles to wait for ack

    logic     clk_i;
    logic     rstn_i;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     irq;
    logic     neoled;

    int errors;
    int checks;
    int cycles;                 // free-running clock count
    int pulses[$];              // finished high pulses, in cycles
    int high_len;               // current high pulse so far
    int cur_p;                  // clocks per tick
    int cur_t0;
    int cur_t1;

    neoled_top dut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .req_i    (req),
        .rsp_o    (rsp),
        .irq_o    (irq),
        .neoled_o (neoled)
    );

    always #10 clk_i = ~clk_i;  // 20 ns period

    always @(posedge clk_i) cycles <= cycles + 1;

    // line monitor ------------------------
    always @(negedge clk_i) begin
        if (neoled === 1'b1) begin
            high_len = high_len + 1;
        end else if (high_len != 0) begin
            pulses.push_back(high_len);     // pulse ended
            high_len = 0;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // bus access --------------------------
    task automatic bus_access(input logic [3:0] addr, input logic [31:0] wdata,
                              input logic wr, output logic [31:0] rdata);
        int   n;
        logic got_ack;
        n = 0;
        got_ack = 1'b0;
        rdata = '0;
        @(posedge clk_i);
        req.addr  <= addr;
        req.wdata <= wdata;
        req.wren  <= wr;
        req.rden  <= ~wr;
        @(posedge clk_i);
        req.wren  <= 1'b0;                  // one-cycle strobe
        req.rden  <= 1'b0;
        while (!got_ack && n < BUS_TIMEOUT) begin
            @(negedge clk_i);
            if (rsp.ack) begin
                got_ack = 1'b1;
                rdata = rsp.rdata;
            end
            n++;
        end
        if (!got_ack) report_error($sformatf("no ack for bus access to address %0h", addr));
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, data, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        bus_access(addr, '0, 1'b0, data);
    endtask

    // control word from fields, t0/t1 high times fixed per run
    task automatic set_ctrl(input logic en, input logic mode, input logic strobe,
                            input int sel, input int t_total, input logic irq_conf);
        logic [31:0] w;
        w = '0;
        w[`NEOLED_CTRL_EN]     = en;
        w[`NEOLED_CTRL_MODE]   = mode;
        w[`NEOLED_CTRL_STROBE] = strobe;
        w[`NEOLED_CTRL_CLKSEL_HI:`NEOLED_CTRL_CLKSEL_LO] = sel[2:0];
        w[`NEOLED_CTRL_TTOT_HI:`NEOLED_CTRL_TTOT_LO]     = t_total[4:0];
        w[`NEOLED_CTRL_T0H_HI:`NEOLED_CTRL_T0H_LO]       = cur_t0[4:0];
        w[`NEOLED_CTRL_T1H_HI:`NEOLED_CTRL_T1H_LO]       = cur_t1[4:0];
        w[`NEOLED_CTRL_IRQ_CONF] = irq_conf;
        cur_p = 2 << sel;                   // 2^(sel+1) clocks per tick
        bus_write(`NEOLED_CTRL_ADDR, w);
    endtask

    // classify n pulses, one if longer than the zero/one midpoint
    task automatic decode_bits(input int n, input int max_cycles, output logic [63:0] bits);
        int wait_n;
        int thresh;
        wait_n = 0;
        bits = '0;
        thresh = ((cur_t0 + 1) + (cur_t1 + 1)) * cur_p / 2;
        while (pulses.size() < n && wait_n < max_cycles) begin
            @(negedge clk_i);
            wait_n++;
        end
        if (pulses.size() < n) begin
            report_error($sformatf("line decoder saw %0d of %0d pulses", pulses.size(), n));
        end else begin
            for (int i = 0; i < n; i++) begin
                bits = {bits[62:0], (pulses.pop_front() > thresh)};   // msb first
            end
        end
    endtask

    task automatic wait_idle(input int max_cycles);
        logic [31:0] st;
        int          start;
        start = cycles;
        st = '0;
        st[`NEOLED_CTRL_TX_BUSY] = 1'b1;
        while ((st[`NEOLED_CTRL_TX_BUSY] || !st[`NEOLED_CTRL_TX_EMPTY])
               && (cycles - start) < max_cycles) begin
            bus_read(`NEOLED_CTRL_ADDR, st);
        end
        if (st[`NEOLED_CTRL_TX_BUSY] || !st[`NEOLED_CTRL_TX_EMPTY]) begin
            report_error("transmitter did not go idle in time");
        end
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (irq !== 1'b1) report_error("interrupt did not rise in time");
    endtask

    // tests -------------------------------
    task automatic test_reset_readback();
        logic [31:0] rd;
        logic [31:0] wr;
        logic [31:0] fixed;
        fixed = '0;
        fixed[`NEOLED_CTRL_BUFS_HI:`NEOLED_CTRL_BUFS_LO] = `NEOLED_FIFO_LOG2;
        fixed[`NEOLED_CTRL_TX_EMPTY] = 1'b1;
        @(negedge clk_i);
        check_val("irq_o after reset", irq, 1'b0);
        check_val("neoled_o after reset", neoled, 1'b0);
        check_val("ack after reset", rsp.ack, 1'b0);
        bus_read(`NEOLED_CTRL_ADDR, rd);
        check_val("ctrl after reset", rd, fixed);
        wr = $urandom() & ~32'h1;           // random fields, enable off
        bus_write(`NEOLED_CTRL_ADDR, wr);
        bus_read(`NEOLED_CTRL_ADDR, rd);
        check_val("ctrl read-back", rd, (wr & 32'h09FF_FC3F) | fixed);  // writable fields
        bus_read(`NEOLED_DATA_ADDR, rd);
        check_val("data word read", rd, 32'h0);
    endtask

    task automatic test_rgb();
        logic [31:0] word;
        logic [63:0] bits;
        set_ctrl(1'b1, 1'b0, 1'b0, 0, 9, 1'b0);
        pulses.delete();
        word = $urandom();
        bus_write(`NEOLED_DATA_ADDR, word);
        decode_bits(`NEOLED_BITS_RGB, 2000, bits);
        check_val("rgb bits", bits[23:0], word[23:0]);
        wait_idle(500);
        check_val("irq_o on empty fifo", irq, 1'b1);   // irq_conf 0
        repeat (50) @(negedge clk_i);       // line must stay quiet
        check_val("pulses after rgb word", pulses.size(), 0);
        check_val("neoled_o after rgb word", neoled, 1'b0);
    endtask

    task automatic test_rgbw();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [63:0] bits;
        set_ctrl(1'b1, 1'b1, 1'b0, 0, 9, 1'b0);
        pulses.delete();
        w0 = $urandom();
        w1 = $urandom();
        bus_write(`NEOLED_DATA_ADDR, w0);
        bus_write(`NEOLED_DATA_ADDR, w1);
        decode_bits(2 * `NEOLED_BITS_RGBW, 4000, bits);
        check_val("rgbw bits", bits, {w0, w1});    // write order
        wait_idle(500);
    endtask

    task automatic test_fifo_irq();
        logic [31:0] st;
        int          accepted;
        int          n;
        set_ctrl(1'b1, 1'b0, 1'b0, 2, 11, 1'b1);   // slow ticks, irq below half
        pulses.delete();
        accepted = 0;
        n = 0;
        bus_read(`NEOLED_CTRL_ADDR, st);
        while (!st[`NEOLED_CTRL_TX_FULL] && n < 16) begin
            bus_write(`NEOLED_DATA_ADDR, $urandom());
            accepted++;
            bus_read(`NEOLED_CTRL_ADDR, st);
            n++;
        end
        check_val("tx_full", st[`NEOLED_CTRL_TX_FULL], 1'b1);
        check_val("tx_half", st[`NEOLED_CTRL_TX_HALF], 1'b1);
        check_val("irq_o while full", irq, 1'b0);
        check_val("accepted writes", accepted, `NEOLED_FIFO_DEPTH + 1);  // one in flight
        wait_irq(20000);
        bus_read(`NEOLED_CTRL_ADDR, st);
        check_val("tx_half after irq", st[`NEOLED_CTRL_TX_HALF], 1'b0);
        wait_idle(30000);
        check_val("decoded bits", pulses.size(), `NEOLED_BITS_RGB * accepted);
    endtask

    task automatic test_strobe();
        logic [31:0] st;
        int          start;
        int          min_len;
        set_ctrl(1'b1, 1'b0, 1'b1, 0, 9, 1'b0);
        pulses.delete();
        start = cycles;
        bus_write(`NEOLED_DATA_ADDR, $urandom());
        bus_read(`NEOLED_CTRL_ADDR, st);
        check_val("tx_busy during strobe", st[`NEOLED_CTRL_TX_BUSY], 1'b1);
        wait_idle(10000);
        min_len = `NEOLED_STROBE_PERIODS * 10 * cur_p - cur_p;  // 127 low bit periods
        check_val("strobe length reached", (cycles - start) >= min_len, 1'b1);
        check_val("pulses during strobe", pulses.size(), 0);
    endtask

    task automatic test_disable();
        logic [31:0] st;
        int          n;
        set_ctrl(1'b1, 1'b0, 1'b0, 0, 9, 1'b0);
        pulses.delete();
        bus_write(`NEOLED_DATA_ADDR, $urandom());
        bus_write(`NEOLED_DATA_ADDR, $urandom());  // second word stays queued
        n = 0;
        while (pulses.size() < 4 && n < 1000) begin
            @(negedge clk_i);
            n++;
        end
        if (pulses.size() < 4) report_error("transmission did not start before disable");
        n = 0;
        while (neoled !== 1'b1 && n < 100) begin   // abort inside a high pulse
            @(negedge clk_i);
            n++;
        end
        if (neoled !== 1'b1) report_error("no high pulse seen before disable");
        set_ctrl(1'b0, 1'b0, 1'b0, 0, 9, 1'b0);    // abort mid-word
        bus_read(`NEOLED_CTRL_ADDR, st);
        check_val("neoled_o after disable", neoled, 1'b0);
        check_val("tx_busy after disable", st[`NEOLED_CTRL_TX_BUSY], 1'b0);
        check_val("tx_empty after disable", st[`NEOLED_CTRL_TX_EMPTY], 1'b1);
    endtask

    // main sequence -----------------------
    initial begin
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        req      = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        high_len = 0;
        cur_p    = 2;
        cur_t0   = 2;                       // zero and one far apart
        cur_t1   = 6;
        void'($urandom(78));
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_reset_readback();
        test_rgb();
        test_rgbw();
        test_fifo_irq();
        test_strobe();
        test_disable();
        $display("neoled_tb done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rtl/neoled_top.sv */
// smart-LED transmitter top level
// register block, TX FIFO, tick prescaler and line serializer
`timescale 1ns/1ps

module neoled_top import neoled_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    output logic     irq_o,
    output logic     neoled_o
);

    ctrl_t        ctrl;
    fifo_status_t fifo_stat;
    tx_entry_t    push_data;
    tx_entry_t    head;
    logic         push;
    logic         pop;
    logic         busy;
    logic         tick;

    neoled_regs u_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req_i),
        .rsp_o       (rsp_o),
        .ctrl_o      (ctrl),
        .fifo_stat_i (fifo_stat),
        .busy_i      (busy),
        .push_o      (push),
        .push_data_o (push_data),
        .irq_o       (irq_o)
    );

    neoled_fifo u_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clear_i     (~ctrl.enable),    // flush while disabled
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .stat_o      (fifo_stat)
    );

    neoled_tick_gen u_tick_gen (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (ctrl.enable),
        .sel_i    (ctrl.clk_prsc),
        .tick_o   (tick)
    );

    neoled_serializer u_serializer (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ctrl_i   (ctrl),
        .tick_i   (tick),
        .head_i   (head),
        .empty_i  (fifo_stat.empty),
        .pop_o    (pop),
        .busy_o   (busy),
        .neoled_o (neoled_o)
    );

endmodule

/* rtl/neoled_serializer.sv */
// LED line serializer
// pops FIFO entries and sends them MSB-first as timed pulses,
// 24 or 32 bits per word, or holds the line low for a reset gap
`timescale 1ns/1ps
`include "neoled_defs.svh"

module neoled_serializer import neoled_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  ctrl_t     ctrl_i,
    input  logic      tick_i,
    input  tx_entry_t head_i,
    input  logic      empty_i,
    output logic      pop_o,
    output logic      busy_o,
    output logic      neoled_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_NEXT_BIT,
        S_PULSE,
        S_STROBE
    } state_t;

    state_t      state_q;
    logic [31:0] sreg_q;            // shifted left, msb at 23 or 31
    logic        mode_q;
    logic        strobe_q;
    logic [4:0]  t_high_q;          // high time of the current bit
    logic [5:0]  bit_cnt_q;         // bits left
    logic [4:0]  tick_cnt_q;
    logic [6:0]  strobe_cnt_q;      // low periods done
    logic        line_q;
    logic        next_bit;

    assign next_bit = mode_q ? sreg_q[31] : sreg_q[23];
    assign pop_o    = (state_q == S_IDLE) && !empty_i && ctrl_i.enable;

    // payload capture and shift -----
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            sreg_q   <= head_i.data;
            mode_q   <= head_i.mode;
            strobe_q <= head_i.strobe;
        end else if (state_q == S_NEXT_BIT && bit_cnt_q != '0) begin
            sreg_q   <= {sreg_q[30:0], 1'b0};
            t_high_q <= next_bit ? ctrl_i.t1_high : ctrl_i.t0_high;
        end
    end

    // control FSM -------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= S_IDLE;
            bit_cnt_q    <= '0;
            tick_cnt_q   <= '0;
            strobe_cnt_q <= '0;
            line_q       <= 1'b0;
        end else if (!ctrl_i.enable) begin
            state_q <= S_IDLE;      // abort at once
            line_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    line_q <= 1'b0;
                    if (pop_o) state_q <= S_LOAD;
                end
                S_LOAD: begin
                    bit_cnt_q    <= mode_q ? 6'(`NEOLED_BITS_RGBW) : 6'(`NEOLED_BITS_RGB);
                    tick_cnt_q   <= '0;
                    strobe_cnt_q <= '0;
                    state_q      <= strobe_q ? S_STROBE : S_NEXT_BIT;
                end
                S_NEXT_BIT: begin
                    tick_cnt_q <= '0;
                    if (bit_cnt_q == '0) begin
                        line_q  <= 1'b0;    // word done
                        state_q <= S_IDLE;
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                        line_q    <= 1'b1;  // start of bit
                        state_q   <= S_PULSE;
                    end
                end
                S_PULSE: begin
                    if (tick_i) begin
                        if (tick_cnt_q == t_high_q) line_q <= 1'b0;
                        if (tick_cnt_q == ctrl_i.t_total) begin
                            state_q <= S_NEXT_BIT;
                        end else begin
                            tick_cnt_q <= tick_cnt_q + 1'b1;
                        end
                    end
                end
                S_STROBE: begin
                    line_q <= 1'b0;
                    if (tick_i) begin
                        if (tick_cnt_q == ctrl_i.t_total) begin
                            tick_cnt_q <= '0;
                            if (strobe_cnt_q == 7'(`NEOLED_STROBE_PERIODS - 1)) begin
                                state_q <= S_IDLE;
                            end else begin
                                strobe_cnt_q <= strobe_cnt_q + 1'b1;
                            end
                        end else begin
                            tick_cnt_q <= tick_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign busy_o   = (state_q != S_IDLE) || pop_o;  // from pop to end of word
    assign neoled_o = line_q;

endmodule

/* rtl/neoled_tick_gen.sv */
// pulse tick prescaler
// free-running counter, one-cycle tick on each rising edge
// of the selected bit, i.e. every 2^(sel+1) cycles
`timescale 1ns/1ps

module neoled_tick_gen (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       enable_i,
    input  logic [2:0] sel_i,
    output logic       tick_o
);

    logic [7:0] cnt_q;              // bit 7 covers sel 7
    logic       bit_q;              // selected bit, last cycle
    logic       tick_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q  <= '0;
            bit_q  <= 1'b0;
            tick_q <= 1'b0;
        end else if (!enable_i) begin
            cnt_q  <= '0;           // hold at zero
            bit_q  <= 1'b0;
            tick_q <= 1'b0;
        end else begin
            cnt_q  <= cnt_q + 1'b1;
            bit_q  <= cnt_q[sel_i];
            tick_q <= cnt_q[sel_i] & ~bit_q;  // rising edge
        end
    end

    assign tick_o = tick_q;

endmodule

/* rtl/neoled_fifo.sv */
// TX FIFO
// ring buffer of queued transfers with synchronous clear,
// drops pushes when full and pops when empty
`timescale 1ns/1ps
`include "neoled_defs.svh"

module neoled_fifo import neoled_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         clear_i,
    input  logic         push_i,
    input  tx_entry_t    push_data_i,
    input  logic         pop_i,
    output tx_entry_t    head_o,
    output fifo_status_t stat_o
);

    localparam int AW = `NEOLED_FIFO_LOG2;

    tx_entry_t   mem [`NEOLED_FIFO_DEPTH];
    logic [AW-1:0] wptr_q;
    logic [AW-1:0] rptr_q;
    logic [AW:0]   count_q;         // one extra bit for full
    logic        push_ok;
    logic        pop_ok;

    assign push_ok = push_i && !stat_o.full;
    assign pop_ok  = pop_i && !stat_o.empty;

    // storage -----------------------
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wptr_q] <= push_data_i;
        end
    end

    // pointers and fill level
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) wptr_q <= wptr_q + 1'b1;
            if (pop_ok)  rptr_q <= rptr_q + 1'b1;
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign head_o       = mem[rptr_q];  // first-word fall-through
    assign stat_o.empty = (count_q == '0);
    assign stat_o.full  = (count_q == (AW+1)'(`NEOLED_FIFO_DEPTH));
    assign stat_o.half  = (count_q >= (AW+1)'(`NEOLED_FIFO_DEPTH / 2));

endmodule

/* rtl/neoled_regs.sv */
// smart-LED register block
// decodes the two-word map, holds the control word, builds the
// status read-back, pushes pixel writes into the TX FIFO and
// generates the level interrupt
`timescale 1ns/1ps
`include "neoled_defs.svh"

module neoled_regs import neoled_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  bus_req_t     req_i,
    output bus_rsp_t     rsp_o,
    output ctrl_t        ctrl_o,
    input  fifo_status_t fifo_stat_i,
    input  logic         busy_i,
    output logic         push_o,
    output tx_entry_t    push_data_o,
    output logic         irq_o
);

    ctrl_t       ctrl_q;
    logic        ctrl_sel;          // control word addressed
    logic        data_sel;          // data word addressed
    logic [31:0] rd_word;           // control/status read-back
    logic        irq_q;

    assign ctrl_sel = (req_i.addr == `NEOLED_CTRL_ADDR);
    assign data_sel = (req_i.addr == `NEOLED_DATA_ADDR);

    // control register -------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_q <= '0;
        end else if (req_i.wren && ctrl_sel) begin
            ctrl_q.enable   <= req_i.wdata[`NEOLED_CTRL_EN];
            ctrl_q.mode     <= req_i.wdata[`NEOLED_CTRL_MODE];
            ctrl_q.strobe   <= req_i.wdata[`NEOLED_CTRL_STROBE];
            ctrl_q.clk_prsc <= req_i.wdata[`NEOLED_CTRL_CLKSEL_HI:`NEOLED_CTRL_CLKSEL_LO];
            ctrl_q.irq_conf <= req_i.wdata[`NEOLED_CTRL_IRQ_CONF];
            ctrl_q.t_total  <= req_i.wdata[`NEOLED_CTRL_TTOT_HI:`NEOLED_CTRL_TTOT_LO];
            ctrl_q.t0_high  <= req_i.wdata[`NEOLED_CTRL_T0H_HI:`NEOLED_CTRL_T0H_LO];
            ctrl_q.t1_high  <= req_i.wdata[`NEOLED_CTRL_T1H_HI:`NEOLED_CTRL_T1H_LO];
        end
    end

    // status word assembly
    always_comb begin
        rd_word = '0;
        rd_word[`NEOLED_CTRL_EN]       = ctrl_q.enable;
        rd_word[`NEOLED_CTRL_MODE]     = ctrl_q.mode;
        rd_word[`NEOLED_CTRL_STROBE]   = ctrl_q.strobe;
        rd_word[`NEOLED_CTRL_CLKSEL_HI:`NEOLED_CTRL_CLKSEL_LO] = ctrl_q.clk_prsc;
        rd_word[`NEOLED_CTRL_BUFS_HI:`NEOLED_CTRL_BUFS_LO]     = 4'(`NEOLED_FIFO_LOG2);
        rd_word[`NEOLED_CTRL_TTOT_HI:`NEOLED_CTRL_TTOT_LO]     = ctrl_q.t_total;
        rd_word[`NEOLED_CTRL_T0H_HI:`NEOLED_CTRL_T0H_LO]       = ctrl_q.t0_high;
        rd_word[`NEOLED_CTRL_T1H_HI:`NEOLED_CTRL_T1H_LO]       = ctrl_q.t1_high;
        rd_word[`NEOLED_CTRL_IRQ_CONF] = ctrl_q.irq_conf;
        rd_word[`NEOLED_CTRL_TX_EMPTY] = fifo_stat_i.empty;  // live flags
        rd_word[`NEOLED_CTRL_TX_HALF]  = fifo_stat_i.half;
        rd_word[`NEOLED_CTRL_TX_FULL]  = fifo_stat_i.full;
        rd_word[`NEOLED_CTRL_TX_BUSY]  = busy_i;
    end

    // bus response, one cycle after the strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_o <= '0;
        end else begin
            rsp_o.ack   <= req_i.wren | req_i.rden;
            rsp_o.rdata <= (req_i.rden && ctrl_sel) ? rd_word : '0;  // data word reads zero
        end
    end

    // fifo push, tagged with the current mode and strobe
    assign push_o             = req_i.wren && data_sel && ctrl_q.enable;
    assign push_data_o.strobe = ctrl_q.strobe;
    assign push_data_o.mode   = ctrl_q.mode;
    assign push_data_o.data   = req_i.wdata;

    // level interrupt
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= ctrl_q.enable &
                     ((~ctrl_q.irq_conf & fifo_stat_i.empty) |   // empty
                      ( ctrl_q.irq_conf & ~fifo_stat_i.half));   // below half
        end
    end

    assign irq_o  = irq_q;
    assign ctrl_o = ctrl_q;

endmodule

/* rtl/neoled_pkg.sv */
// smart-LED transmitter types
// bus request/response, control fields, FIFO entry and FIFO flags
package neoled_pkg;

    // writable control fields
    typedef struct packed {
        logic       enable;     // module on
        logic       mode;       // 0 rgb, 1 rgbw
        logic       strobe;     // data writes become reset commands
        logic [2:0] clk_prsc;   // tick rate select
        logic       irq_conf;   // irq condition
        logic [4:0] t_total;    // ticks per bit minus one
        logic [4:0] t0_high;    // zero high time minus one
        logic [4:0] t1_high;    // one high time minus one
    } ctrl_t;

    // one queued transfer
    typedef struct packed {
        logic        strobe;    // reset command, data ignored
        logic        mode;      // word length of this entry
        logic [31:0] data;      // pixel, msb aligned to bit 23 or 31
    } tx_entry_t;

    typedef struct packed {
        logic empty;
        logic half;             // at least half full
        logic full;
    } fifo_status_t;

    // register bus ------------------
    typedef struct packed {
        logic [3:0]  addr;      // byte offset
        logic [31:0] wdata;
        logic        wren;
        logic        rden;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;     // zero unless ack
        logic        ack;
    } bus_rsp_t;

endpackage

/* rtl/neoled_defs.svh */
// smart-LED transmitter constants
// register map, control word bit positions, FIFO size and
// per-word bit counts shared by RTL and testbench
`ifndef NEOLED_DEFS_SVH
`define NEOLED_DEFS_SVH

// register map ----------------
`define NEOLED_CTRL_ADDR      4'h0  // control and status word
`define NEOLED_DATA_ADDR      4'h4  // pixel data, write only

// control word bits -----------
`define NEOLED_CTRL_EN        0     // module enable
`define NEOLED_CTRL_MODE      1     // 0 rgb, 1 rgbw
`define NEOLED_CTRL_STROBE    2     // queue reset gaps instead of data
`define NEOLED_CTRL_CLKSEL_LO 3
`define NEOLED_CTRL_CLKSEL_HI 5
`define NEOLED_CTRL_BUFS_LO   6     // log2 of fifo depth, read only
`define NEOLED_CTRL_BUFS_HI   9
`define NEOLED_CTRL_TTOT_LO   10
`define NEOLED_CTRL_TTOT_HI   14
`define NEOLED_CTRL_T0H_LO    15
`define NEOLED_CTRL_T0H_HI    19
`define NEOLED_CTRL_T1H_LO    20
`define NEOLED_CTRL_T1H_HI    24
`define NEOLED_CTRL_IRQ_CONF  27    // 0 irq on empty, 1 irq below half
`define NEOLED_CTRL_TX_EMPTY  28
`define NEOLED_CTRL_TX_HALF   29
`define NEOLED_CTRL_TX_FULL   30
`define NEOLED_CTRL_TX_BUSY   31

// sizes -----------------------
`define NEOLED_FIFO_DEPTH     4     // power of two
`define NEOLED_FIFO_LOG2      2
`define NEOLED_BITS_RGB       24
`define NEOLED_BITS_RGBW      32
`define NEOLED_STROBE_PERIODS 127   // low bit periods per reset command

`endif
